//--- logic/oflow_calc_iou.sv
// Intersection-over-union of two boxes as an 8-bit fraction
// One register stage from box inputs to iou, used inside the metric
module oflow_calc_iou (
	input  logic                                clk,
	input  logic                                reset_N,
	input  logic [4*oflow_pkg::COORD_W-1:0]     bbox_position_frame_k,
	input  logic [4*oflow_pkg::COORD_W-1:0]     bbox_position_frame_history,
	input  logic [oflow_pkg::COORD_W-1:0]       bbox_w_frame_k,
	input  logic [oflow_pkg::COORD_W-1:0]       bbox_h_frame_k,
	input  logic [oflow_pkg::COORD_W-1:0]       bbox_w_frame_history,
	input  logic [oflow_pkg::COORD_W-1:0]       bbox_h_frame_history,
	output logic [oflow_pkg::IOU_W-1:0]         iou
);

	// Zero-extended product of two coordinates
	function automatic logic [2*oflow_pkg::COORD_W-1:0] area(
		input logic [oflow_pkg::COORD_W-1:0] a,
		input logic [oflow_pkg::COORD_W-1:0] b
	);
		return {{oflow_pkg::COORD_W{1'b0}}, a} * {{oflow_pkg::COORD_W{1'b0}}, b};
	endfunction

	logic [oflow_pkg::COORD_W-1:0] k_xtl, k_ytl, k_xbr, k_ybr;
	logic [oflow_pkg::COORD_W-1:0] h_xtl, h_ytl, h_xbr, h_ybr;
	logic [oflow_pkg::COORD_W-1:0] ov_xtl, ov_ytl, ov_xbr, ov_ybr;
	logic [oflow_pkg::COORD_W-1:0] ov_w;
	logic [oflow_pkg::COORD_W-1:0] ov_h;
	logic [2*oflow_pkg::COORD_W-1:0] inter;
	logic [2*oflow_pkg::COORD_W:0] union_a;
	logic [2*oflow_pkg::COORD_W+oflow_pkg::IOU_W:0] quot;
	logic [oflow_pkg::IOU_W-1:0] iou_next;

	assign {k_xtl, k_ytl, k_xbr, k_ybr} = bbox_position_frame_k;
	assign {h_xtl, h_ytl, h_xbr, h_ybr} = bbox_position_frame_history;

	// --------------------------------------------------
	// Overlap rectangle
	// --------------------------------------------------
	assign ov_xtl = (k_xtl > h_xtl) ? k_xtl : h_xtl;
	assign ov_ytl = (k_ytl > h_ytl) ? k_ytl : h_ytl;
	assign ov_xbr = (k_xbr < h_xbr) ? k_xbr : h_xbr;
	assign ov_ybr = (k_ybr < h_ybr) ? k_ybr : h_ybr;
	// Disjoint boxes clamp to zero
	assign ov_w = (ov_xbr > ov_xtl) ? ov_xbr - ov_xtl : '0;
	assign ov_h = (ov_ybr > ov_ytl) ? ov_ybr - ov_ytl : '0;
	assign inter = area(ov_w, ov_h);

	// Union = both areas minus the shared part
	assign union_a = {1'b0, area(bbox_w_frame_k, bbox_h_frame_k)}
		+ {1'b0, area(bbox_w_frame_history, bbox_h_frame_history)}
		- {1'b0, inter};

	// Fraction scaled by 256
	assign quot = {1'b0, inter, {oflow_pkg::IOU_W{1'b0}}}
		/ {{oflow_pkg::IOU_W{1'b0}}, union_a};

	always_comb begin
		if (union_a == '0)
			iou_next = '0;
		else if (|quot[2*oflow_pkg::COORD_W+oflow_pkg::IOU_W:oflow_pkg::IOU_W])
			// Full overlap gives 256, saturate
			iou_next = '1;
		else
			iou_next = quot[oflow_pkg::IOU_W-1:0];
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			iou <= '0;
		else
			iou <= iou_next;
	end

endmodule

//--- logic/oflow_core.sv
// Top of the matching core
// Matcher feeds pairs to the metric pipeline and collects the scores
module oflow_core (
	input  logic                              clk,
	input  logic                              reset_N,
	input  logic                              cur_valid,
	input  logic [oflow_pkg::FEAT_W-1:0]      cur_features,
	output logic                              cur_credit_return,
	input  logic                              prev_wr,
	input  logic [oflow_pkg::PREV_AW-1:0]     prev_addr,
	input  logic [oflow_pkg::FEAT_W-1:0]      prev_wdata,
	input  logic                              prev_clear,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    iou_weight,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    w_weight,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    h_weight,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    color1_weight,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    color2_weight,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    dhistory_weight,
	output logic                              match_valid,
	output logic                              match_found,
	output logic [oflow_pkg::ID_W-1:0]        match_id,
	output logic [oflow_pkg::SCORE_W-1:0]     match_score,
	input  logic                              match_credit_return
);

	// Pair stream, matcher to metric
	logic                          pair_valid;
	logic [oflow_pkg::FEAT_W-1:0]  pair_cur;
	logic [oflow_pkg::FEAT_W-1:0]  pair_prev;
	logic [oflow_pkg::PREV_AW-1:0] pair_index;
	// Score stream back, SIM_LATENCY later
	logic                          score_valid;
	logic [oflow_pkg::SCORE_W-1:0] score;
	logic [oflow_pkg::PREV_AW-1:0] score_index;

	oflow_track_match u_track_match (
		.clk                 (clk),
		.reset_N             (reset_N),
		.cur_valid           (cur_valid),
		.cur_features        (cur_features),
		.cur_credit_return   (cur_credit_return),
		.prev_wr             (prev_wr),
		.prev_addr           (prev_addr),
		.prev_wdata          (prev_wdata),
		.prev_clear          (prev_clear),
		.pair_valid          (pair_valid),
		.pair_cur            (pair_cur),
		.pair_prev           (pair_prev),
		.pair_index          (pair_index),
		.score_valid         (score_valid),
		.score               (score),
		.score_index         (score_index),
		.match_valid         (match_valid),
		.match_found         (match_found),
		.match_id            (match_id),
		.match_score         (match_score),
		.match_credit_return (match_credit_return)
	);

	oflow_similarity_metric u_similarity_metric (
		.clk             (clk),
		.reset_N         (reset_N),
		.pair_valid      (pair_valid),
		.pair_cur        (pair_cur),
		.pair_prev       (pair_prev),
		.pair_index      (pair_index),
		.iou_weight      (iou_weight),
		.w_weight        (w_weight),
		.h_weight        (h_weight),
		.color1_weight   (color1_weight),
		.color2_weight   (color2_weight),
		.dhistory_weight (dhistory_weight),
		.score_valid     (score_valid),
		.score           (score),
		.score_index     (score_index)
	);

endmodule

//--- logic/oflow_pkg.sv
// Shared constants of the optical-flow matching core
// Feature word layout, table and credit sizes, FSM encodings
// All users reference these by scoped names
package oflow_pkg;

	// --------------------------------------------------
	// Feature word layout, top bit down
	// --------------------------------------------------
	localparam int FEAT_W    = 156;
	localparam int CM_W      = 22;
	localparam int CM_LSB    = 134;
	localparam int POS_W     = 44;
	localparam int POS_LSB   = 90;
	localparam int WID_W     = 11;
	localparam int WID_LSB   = 79;
	localparam int HGT_W     = 11;
	localparam int HGT_LSB   = 68;
	localparam int COL_W     = 24;
	localparam int COL1_LSB  = 44;
	localparam int COL2_LSB  = 20;
	localparam int DHIST_W   = 8;
	localparam int DHIST_LSB = 12;
	localparam int ID_W      = 12;
	localparam int ID_LSB    = 0;

	// Box corners {x_tl, y_tl, x_br, y_br}
	localparam int COORD_W = 11;
	// One RGB channel
	localparam int CHAN_W  = 8;

	// --------------------------------------------------
	// Scoring
	// --------------------------------------------------
	localparam int IOU_W       = 8;
	localparam int WEIGHT_W    = 8;
	localparam int SCORE_W     = 32;
	localparam int NUM_METRICS = 6;
	localparam int SIM_LATENCY = 3;
	// Full overlap in 8-bit fraction form
	localparam logic [COORD_W-1:0] IOU_ONE = COORD_W'(256);

	// Previous-object table
	localparam int NUM_PREV = 8;
	localparam int PREV_AW  = 3;
	localparam logic [PREV_AW-1:0] LAST_PREV = PREV_AW'(NUM_PREV - 1);

	// Credits on both streaming sides
	localparam int CUR_CREDITS   = 2;
	localparam int MATCH_CREDITS = 2;
	localparam int CUR_PTR_W     = 1;
	localparam int CRED_W        = 2;
	localparam logic [CRED_W-1:0] CUR_FULL        = CRED_W'(CUR_CREDITS);
	localparam logic [CRED_W-1:0] MATCH_CRED_INIT = CRED_W'(MATCH_CREDITS);

	// Matcher FSM states
	localparam logic [1:0] ST_IDLE   = 2'd0;
	localparam logic [1:0] ST_ISSUE  = 2'd1;
	localparam logic [1:0] ST_DRAIN  = 2'd2;
	localparam logic [1:0] ST_REPORT = 2'd3;

endpackage

//--- logic/oflow_similarity_metric.sv
// Weighted similarity score of one current/previous feature pair
// Three pipeline stages, a new pair may enter every cycle
// Valid and table index travel alongside each pair
module oflow_similarity_metric (
	input  logic                              clk,
	input  logic                              reset_N,
	input  logic                              pair_valid,
	input  logic [oflow_pkg::FEAT_W-1:0]      pair_cur,
	input  logic [oflow_pkg::FEAT_W-1:0]      pair_prev,
	input  logic [oflow_pkg::PREV_AW-1:0]     pair_index,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    iou_weight,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    w_weight,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    h_weight,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    color1_weight,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    color2_weight,
	input  logic [oflow_pkg::WEIGHT_W-1:0]    dhistory_weight,
	output logic                              score_valid,
	output logic [oflow_pkg::SCORE_W-1:0]     score,
	output logic [oflow_pkg::PREV_AW-1:0]     score_index
);

	function automatic logic [oflow_pkg::COORD_W-1:0] abs_diff(
		input logic [oflow_pkg::COORD_W-1:0] a,
		input logic [oflow_pkg::COORD_W-1:0] b
	);
		return (a > b) ? a - b : b - a;
	endfunction

	// Sum of per-channel absolute differences, at most 765
	function automatic logic [oflow_pkg::COORD_W-1:0] color_diff(
		input logic [oflow_pkg::COL_W-1:0] a,
		input logic [oflow_pkg::COL_W-1:0] b
	);
		logic [oflow_pkg::COORD_W-1:0] acc;
		acc = '0;
		for (int i = 0; i < oflow_pkg::COL_W / oflow_pkg::CHAN_W; i++) begin
			acc = acc + abs_diff(
				{{(oflow_pkg::COORD_W-oflow_pkg::CHAN_W){1'b0}},
					a[oflow_pkg::CHAN_W*i +: oflow_pkg::CHAN_W]},
				{{(oflow_pkg::COORD_W-oflow_pkg::CHAN_W){1'b0}},
					b[oflow_pkg::CHAN_W*i +: oflow_pkg::CHAN_W]});
		end
		return acc;
	endfunction

	// Weight times term at full score width
	function automatic logic [oflow_pkg::SCORE_W-1:0] weigh(
		input logic [oflow_pkg::WEIGHT_W-1:0] w,
		input logic [oflow_pkg::COORD_W-1:0]  t
	);
		logic [oflow_pkg::SCORE_W-1:0] w_ext;
		logic [oflow_pkg::SCORE_W-1:0] t_ext;
		w_ext = {{(oflow_pkg::SCORE_W-oflow_pkg::WEIGHT_W){1'b0}}, w};
		t_ext = {{(oflow_pkg::SCORE_W-oflow_pkg::COORD_W){1'b0}}, t};
		return w_ext * t_ext;
	endfunction

	logic [oflow_pkg::IOU_W-1:0]   iou;
	logic [oflow_pkg::COORD_W-1:0] iou_term;
	logic                          s1_valid;
	logic [oflow_pkg::PREV_AW-1:0] s1_index;
	logic [oflow_pkg::COORD_W-1:0] s1_w;
	logic [oflow_pkg::COORD_W-1:0] s1_h;
	logic [oflow_pkg::COORD_W-1:0] s1_c1;
	logic [oflow_pkg::COORD_W-1:0] s1_c2;
	logic [oflow_pkg::COORD_W-1:0] s1_hist;
	logic                          s2_valid;
	logic [oflow_pkg::PREV_AW-1:0] s2_index;
	logic [oflow_pkg::SCORE_W-1:0] s2_sum;

	// --------------------------------------------------
	// Stage 1: differences, IoU register sits in the IoU block
	// --------------------------------------------------
	oflow_calc_iou u_calc_iou (
		.clk                         (clk),
		.reset_N                     (reset_N),
		.bbox_position_frame_k       (pair_cur[oflow_pkg::POS_LSB +: oflow_pkg::POS_W]),
		.bbox_position_frame_history (pair_prev[oflow_pkg::POS_LSB +: oflow_pkg::POS_W]),
		.bbox_w_frame_k              (pair_cur[oflow_pkg::WID_LSB +: oflow_pkg::WID_W]),
		.bbox_h_frame_k              (pair_cur[oflow_pkg::HGT_LSB +: oflow_pkg::HGT_W]),
		.bbox_w_frame_history        (pair_prev[oflow_pkg::WID_LSB +: oflow_pkg::WID_W]),
		.bbox_h_frame_history        (pair_prev[oflow_pkg::HGT_LSB +: oflow_pkg::HGT_W]),
		.iou                         (iou)
	);

	always_ff @(posedge clk) begin
		s1_index <= pair_index;
		s1_w     <= abs_diff(pair_cur[oflow_pkg::WID_LSB +: oflow_pkg::WID_W],
			pair_prev[oflow_pkg::WID_LSB +: oflow_pkg::WID_W]);
		s1_h     <= abs_diff(pair_cur[oflow_pkg::HGT_LSB +: oflow_pkg::HGT_W],
			pair_prev[oflow_pkg::HGT_LSB +: oflow_pkg::HGT_W]);
		s1_c1    <= color_diff(pair_cur[oflow_pkg::COL1_LSB +: oflow_pkg::COL_W],
			pair_prev[oflow_pkg::COL1_LSB +: oflow_pkg::COL_W]);
		s1_c2    <= color_diff(pair_cur[oflow_pkg::COL2_LSB +: oflow_pkg::COL_W],
			pair_prev[oflow_pkg::COL2_LSB +: oflow_pkg::COL_W]);
		// History term is the stored object's count
		s1_hist  <= {{(oflow_pkg::COORD_W-oflow_pkg::DHIST_W){1'b0}},
			pair_prev[oflow_pkg::DHIST_LSB +: oflow_pkg::DHIST_W]};
	end

	// --------------------------------------------------
	// Stage 2: weighted sum, stage 3: average
	// --------------------------------------------------
	assign iou_term = oflow_pkg::IOU_ONE - {{(oflow_pkg::COORD_W-oflow_pkg::IOU_W){1'b0}}, iou};

	always_ff @(posedge clk) begin
		s2_index    <= s1_index;
		s2_sum      <= weigh(iou_weight, iou_term) + weigh(w_weight, s1_w)
			+ weigh(h_weight, s1_h) + weigh(color1_weight, s1_c1)
			+ weigh(color2_weight, s1_c2) + weigh(dhistory_weight, s1_hist);
		score_index <= s2_index;
		score       <= s2_sum / oflow_pkg::NUM_METRICS;
	end

	// Valid pipe
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			s1_valid    <= 1'b0;
			s2_valid    <= 1'b0;
			score_valid <= 1'b0;
		end else begin
			s1_valid    <= pair_valid;
			s2_valid    <= s1_valid;
			score_valid <= s2_valid;
		end
	end

endmodule

//--- logic/oflow_track_match.sv
// Matcher: previous-object table, current-object credit buffer and scan FSM
// Streams all table entries through the metric and keeps the lowest score
// Results leave under consumer credits
module oflow_track_match (
	input  logic                              clk,
	input  logic                              reset_N,
	input  logic                              cur_valid,
	input  logic [oflow_pkg::FEAT_W-1:0]      cur_features,
	output logic                              cur_credit_return,
	input  logic                              prev_wr,
	input  logic [oflow_pkg::PREV_AW-1:0]     prev_addr,
	input  logic [oflow_pkg::FEAT_W-1:0]      prev_wdata,
	input  logic                              prev_clear,
	output logic                              pair_valid,
	output logic [oflow_pkg::FEAT_W-1:0]      pair_cur,
	output logic [oflow_pkg::FEAT_W-1:0]      pair_prev,
	output logic [oflow_pkg::PREV_AW-1:0]     pair_index,
	input  logic                              score_valid,
	input  logic [oflow_pkg::SCORE_W-1:0]     score,
	input  logic [oflow_pkg::PREV_AW-1:0]     score_index,
	output logic                              match_valid,
	output logic                              match_found,
	output logic [oflow_pkg::ID_W-1:0]        match_id,
	output logic [oflow_pkg::SCORE_W-1:0]     match_score,
	input  logic                              match_credit_return
);

	logic [oflow_pkg::FEAT_W-1:0]    prev_mem [oflow_pkg::NUM_PREV];
	logic [oflow_pkg::NUM_PREV-1:0]  prev_vld;
	logic [oflow_pkg::NUM_PREV-1:0]  scan_mask;
	logic [oflow_pkg::FEAT_W-1:0]    fifo_mem [oflow_pkg::CUR_CREDITS];
	logic [oflow_pkg::CUR_PTR_W-1:0] wr_ptr;
	logic [oflow_pkg::CUR_PTR_W-1:0] rd_ptr;
	logic [oflow_pkg::CRED_W-1:0]    fifo_cnt;
	logic [oflow_pkg::FEAT_W-1:0]    cur_reg;
	logic [1:0]                      state;
	logic [oflow_pkg::PREV_AW-1:0]   issue_cnt;
	logic                            scan_start;
	logic [oflow_pkg::CRED_W-1:0]    credits;
	logic                            take;
	logic                            best_found;
	logic [oflow_pkg::ID_W-1:0]      best_id;
	logic [oflow_pkg::SCORE_W-1:0]   best_score;

	// --------------------------------------------------
	// Previous-object table
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (prev_wr)
			prev_mem[prev_addr] <= prev_wdata;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			prev_vld <= '0;
		end else begin
			if (prev_clear)
				prev_vld <= '0;
			// Write after clear so a same-cycle write survives
			if (prev_wr)
				prev_vld[prev_addr] <= 1'b1;
		end
	end

	// --------------------------------------------------
	// Current-object FIFO, one slot per host credit
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (cur_valid)
			fifo_mem[wr_ptr] <= cur_features;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			wr_ptr   <= '0;
			rd_ptr   <= '0;
			fifo_cnt <= '0;
		end else begin
			if (cur_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (scan_start)
				rd_ptr <= rd_ptr + 1'b1;
			fifo_cnt <= fifo_cnt + {1'b0, cur_valid} - {1'b0, scan_start};
		end
	end

	// Pop frees a host slot
	assign scan_start        = (state == oflow_pkg::ST_IDLE) && (fifo_cnt != '0);
	assign cur_credit_return = scan_start;

	// --------------------------------------------------
	// Scan FSM
	// --------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state     <= oflow_pkg::ST_IDLE;
			issue_cnt <= '0;
		end else begin
			case (state)
				oflow_pkg::ST_IDLE: begin
					// Entry 0 goes out with the pop
					if (scan_start) begin
						state     <= oflow_pkg::ST_ISSUE;
						issue_cnt <= issue_cnt + 1'b1;
					end
				end
				oflow_pkg::ST_ISSUE: begin
					issue_cnt <= issue_cnt + 1'b1;
					if (issue_cnt == oflow_pkg::LAST_PREV)
						state <= oflow_pkg::ST_DRAIN;
				end
				oflow_pkg::ST_DRAIN: begin
					if (score_valid && score_index == oflow_pkg::LAST_PREV)
						state <= oflow_pkg::ST_REPORT;
				end
				default: begin
					// Report waits here for a consumer credit
					if (match_valid)
						state <= oflow_pkg::ST_IDLE;
				end
			endcase
		end
	end

	// Object under scan and its table snapshot
	always_ff @(posedge clk) begin
		if (scan_start) begin
			cur_reg   <= fifo_mem[rd_ptr];
			scan_mask <= prev_vld;
		end
	end

	// Pair stream into the metric, one entry per cycle
	assign pair_valid = scan_start || (state == oflow_pkg::ST_ISSUE);
	assign pair_index = issue_cnt;
	assign pair_cur   = (state == oflow_pkg::ST_IDLE) ? fifo_mem[rd_ptr] : cur_reg;
	assign pair_prev  = prev_mem[issue_cnt];

	// --------------------------------------------------
	// Minimum over valid entries, strict less-than keeps the lower index
	// --------------------------------------------------
	assign take = score_valid && scan_mask[score_index]
		&& (!best_found || score < best_score);

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			best_found <= 1'b0;
			best_id    <= '0;
			best_score <= '1;
		end else if (scan_start) begin
			best_found <= 1'b0;
			best_id    <= '0;
			best_score <= '1;
		end else if (take) begin
			best_found <= 1'b1;
			best_id    <= prev_mem[score_index][oflow_pkg::ID_LSB +: oflow_pkg::ID_W];
			best_score <= score;
		end
	end

	// --------------------------------------------------
	// Result port and consumer credits
	// --------------------------------------------------
	assign match_valid = (state == oflow_pkg::ST_REPORT) && (credits != '0);
	assign match_found = best_found;
	assign match_id    = best_id;
	assign match_score = best_score;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			credits <= oflow_pkg::MATCH_CRED_INIT;
		else
			credits <= credits + {1'b0, match_credit_return} - {1'b0, match_valid};
	end

endmodule

//--- oflow.f
logic/oflow_pkg.sv
logic/oflow_calc_iou.sv
logic/oflow_similarity_metric.sv
logic/oflow_track_match.sv
logic/oflow_core.sv
tb/oflow_core_assertions.sv
tb/oflow_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -sv -Wno-fatal \
	--top-module oflow_core_tb -f oflow.f -o oflow_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/oflow_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -q "^TB PASSED$"; then
	exit 0
fi
exit 1

//--- tb/oflow_core_assertions.sv
// Bound checks on the matcher's credit and result handshakes
// Attached to every oflow_track_match instance by the bind below
module oflow_core_assertions (
	input logic                           clk,
	input logic                           reset_N,
	input logic                           cur_valid,
	input logic [oflow_pkg::CRED_W-1:0]   fifo_cnt,
	input logic                           match_valid,
	input logic                           match_credit_return,
	input logic                           cur_credit_return
);

	// Results out minus credits back, counted apart from the matcher
	logic [oflow_pkg::CRED_W:0] outstanding;

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N)
			outstanding <= '0;
		else
			outstanding <= outstanding + {{oflow_pkg::CRED_W{1'b0}}, match_valid}
				- {{oflow_pkg::CRED_W{1'b0}}, match_credit_return};
	end

	// Host never sends into a full buffer
	a_no_overflow: assert property (@(posedge clk) disable iff (!reset_N)
		cur_valid |-> fifo_cnt != oflow_pkg::CUR_FULL)
		else $error("cur_valid while current-object buffer full");

	// Result only while the consumer still has buffer room
	a_credit: assert property (@(posedge clk) disable iff (!reset_N)
		match_valid |-> outstanding < oflow_pkg::MATCH_CREDITS)
		else $error("match_valid with zero credits");

	// Single-cycle pulses
	a_match_pulse: assert property (@(posedge clk) disable iff (!reset_N)
		match_valid |=> !match_valid)
		else $error("match_valid longer than one cycle");
	a_ret_pulse: assert property (@(posedge clk) disable iff (!reset_N)
		cur_credit_return |=> !cur_credit_return)
		else $error("cur_credit_return longer than one cycle");

	// Quiet outputs as reset lifts
	a_reset_quiet: assert property (@(posedge clk)
		$rose(reset_N) |-> !match_valid && !cur_credit_return)
		else $error("handshake outputs active after reset");

endmodule

bind oflow_track_match oflow_core_assertions u_core_assertions (
	.clk                 (clk),
	.reset_N             (reset_N),
	.cur_valid           (cur_valid),
	.fifo_cnt            (fifo_cnt),
	.match_valid         (match_valid),
	.match_credit_return (match_credit_return),
	.cur_credit_return   (cur_credit_return)
);

//--- tb/oflow_core_tb.sv
// Testbench for the matching core
// Loads the table, sends current objects under host credits and checks results
// against a reference model kept in the testbench
module oflow_core_tb;

	localparam int NUM_OBJECTS = 13;
	localparam int FW = oflow_pkg::FEAT_W;

	logic clk = 1'b0;
	logic reset_N = 1'b0;
	logic cur_valid = 1'b0;
	logic [FW-1:0] cur_features = '0;
	logic cur_credit_return;
	logic prev_wr = 1'b0;
	logic [oflow_pkg::PREV_AW-1:0] prev_addr = '0;
	logic [FW-1:0] prev_wdata = '0;
	logic prev_clear = 1'b0;
	logic [7:0] iou_weight = 8'd3;
	logic [7:0] w_weight = 8'd2;
	logic [7:0] h_weight = 8'd2;
	logic [7:0] color1_weight = 8'd1;
	logic [7:0] color2_weight = 8'd1;
	logic [7:0] dhistory_weight = 8'd4;
	logic match_valid;
	logic match_found;
	logic [oflow_pkg::ID_W-1:0] match_id;
	logic [oflow_pkg::SCORE_W-1:0] match_score;
	logic match_credit_return = 1'b0;

	integer seed = 51;
	int errors = 0;
	int checks = 0;
	int host_credits = oflow_pkg::CUR_CREDITS;
	int objs_sent = 0;
	int cur_returns = 0;
	int match_cnt = 0;
	int owed = 0;
	bit hold_credits = 1'b0;

	// Model of the table and expected results in send order
	logic [FW-1:0] tab [8];
	bit tab_v [8];
	bit q_found [$];
	logic [11:0] q_id [$];
	logic [31:0] q_score [$];

	oflow_core u_oflow_core (.*);

	always #10 clk = ~clk;

	// Watchdog
	initial begin
		#((NUM_OBJECTS * 40 + 2000) * 20);
		$display("Timeout: simulation ran past its time limit");
		$display("TB FAILED");
		$finish;
	end

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------
	function automatic logic [FW-1:0] pack_obj(input logic [10:0] xtl, ytl, w, h,
		input logic [23:0] c1, c2, input logic [7:0] hist, input logic [11:0] id);
		logic [FW-1:0] f;
		logic [10:0] xbr;
		logic [10:0] ybr;
		xbr = xtl + w;
		ybr = ytl + h;
		f = '0;
		f[oflow_pkg::POS_LSB +: oflow_pkg::POS_W] = {xtl, ytl, xbr, ybr};
		f[oflow_pkg::WID_LSB +: oflow_pkg::WID_W] = w;
		f[oflow_pkg::HGT_LSB +: oflow_pkg::HGT_W] = h;
		f[oflow_pkg::COL1_LSB +: oflow_pkg::COL_W] = c1;
		f[oflow_pkg::COL2_LSB +: oflow_pkg::COL_W] = c2;
		f[oflow_pkg::DHIST_LSB +: oflow_pkg::DHIST_W] = hist;
		f[oflow_pkg::ID_LSB +: oflow_pkg::ID_W] = id;
		return f;
	endfunction

	function automatic int absd(input int a, input int b);
		return (a > b) ? a - b : b - a;
	endfunction

	function automatic int col_sum(input logic [23:0] a, input logic [23:0] b);
		return absd(a[7:0], b[7:0]) + absd(a[15:8], b[15:8]) + absd(a[23:16], b[23:16]);
	endfunction

	function automatic int ref_iou(input logic [FW-1:0] c, input logic [FW-1:0] p);
		logic [43:0] kp;
		logic [43:0] hp;
		longint ow, oh, inter, uni, q;
		kp = c[oflow_pkg::POS_LSB +: oflow_pkg::POS_W];
		hp = p[oflow_pkg::POS_LSB +: oflow_pkg::POS_W];
		ow = longint'((kp[21:11] < hp[21:11]) ? kp[21:11] : hp[21:11])
			- longint'((kp[43:33] > hp[43:33]) ? kp[43:33] : hp[43:33]);
		oh = longint'((kp[10:0] < hp[10:0]) ? kp[10:0] : hp[10:0])
			- longint'((kp[32:22] > hp[32:22]) ? kp[32:22] : hp[32:22]);
		if (ow < 0) ow = 0;
		if (oh < 0) oh = 0;
		inter = ow * oh;
		uni = longint'(c[oflow_pkg::WID_LSB +: 11]) * c[oflow_pkg::HGT_LSB +: 11]
			+ longint'(p[oflow_pkg::WID_LSB +: 11]) * p[oflow_pkg::HGT_LSB +: 11] - inter;
		if (uni == 0)
			return 0;
		q = (inter * 256) / uni;
		return (q > 255) ? 255 : int'(q);
	endfunction

	function automatic logic [31:0] ref_score(input logic [FW-1:0] c, input logic [FW-1:0] p);
		longint sum;
		sum = longint'(iou_weight) * (256 - ref_iou(c, p))
			+ longint'(w_weight) * absd(c[oflow_pkg::WID_LSB +: 11], p[oflow_pkg::WID_LSB +: 11])
			+ longint'(h_weight) * absd(c[oflow_pkg::HGT_LSB +: 11], p[oflow_pkg::HGT_LSB +: 11])
			+ longint'(color1_weight) * col_sum(c[oflow_pkg::COL1_LSB +: 24],
				p[oflow_pkg::COL1_LSB +: 24])
			+ longint'(color2_weight) * col_sum(c[oflow_pkg::COL2_LSB +: 24],
				p[oflow_pkg::COL2_LSB +: 24])
			+ longint'(dhistory_weight) * p[oflow_pkg::DHIST_LSB +: 8];
		return 32'(sum / oflow_pkg::NUM_METRICS);
	endfunction

	// Lowest score over valid entries, first index wins a tie
	function automatic void best_match(input logic [FW-1:0] c, output bit found,
		output logic [11:0] id, output logic [31:0] score);
		logic [31:0] s;
		found = 1'b0;
		id = '0;
		score = '1;
		for (int i = 0; i < 8; i++) begin
			s = ref_score(c, tab[i]);
			if (tab_v[i] && (!found || s < score)) begin
				found = 1'b1;
				id = tab[i][oflow_pkg::ID_LSB +: 12];
				score = s;
			end
		end
	endfunction

	// --------------------------------------------------
	// Stimulus helpers
	// --------------------------------------------------
	task automatic rand_obj(input logic [11:0] id, output logic [FW-1:0] f);
		logic [31:0] r1, r2, r3;
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		// Small area so boxes often overlap
		f = pack_obj({3'b0, r1[7:0]}, {3'b0, r1[15:8]}, 11'd1 + r1[22:16], 11'd1 + r1[29:23],
			r2[23:0], r3[23:0], {r2[31:24]}, id);
	endtask

	task automatic write_entry(input int idx, input logic [FW-1:0] f);
		@(posedge clk);
		#2;
		prev_wr = 1'b1;
		prev_addr = idx[2:0];
		prev_wdata = f;
		tab[idx] = f;
		tab_v[idx] = 1'b1;
		@(posedge clk);
		#2;
		prev_wr = 1'b0;
	endtask

	task automatic clear_table();
		@(posedge clk);
		#2;
		prev_clear = 1'b1;
		for (int i = 0; i < 8; i++)
			tab_v[i] = 1'b0;
		@(posedge clk);
		#2;
		prev_clear = 1'b0;
	endtask

	// Waits for a host credit, then sends one object
	task automatic send_obj(input logic [FW-1:0] f, input bit found,
		input logic [11:0] id, input logic [31:0] score);
		@(posedge clk);
		#2;
		while (host_credits == 0) begin
			@(posedge clk);
			#2;
		end
		q_found.push_back(found);
		q_id.push_back(id);
		q_score.push_back(score);
		cur_valid = 1'b1;
		cur_features = f;
		host_credits--;
		objs_sent++;
		@(posedge clk);
		#2;
		cur_valid = 1'b0;
	endtask

	task automatic send_ref(input logic [FW-1:0] f);
		bit fd;
		logic [11:0] id;
		logic [31:0] sc;
		best_match(f, fd, id, sc);
		send_obj(f, fd, id, sc);
	endtask

	task automatic wait_done();
		while (q_found.size() != 0 || host_credits != oflow_pkg::CUR_CREDITS) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic end_test(input string name);
		wait_done();
		$display("[%0t] test %s finished, %0d errors so far", $time, name, errors);
	endtask

	// --------------------------------------------------
	// Monitors: host credits, comparison, consumer credits
	// --------------------------------------------------
	always @(posedge clk) begin
		if (cur_credit_return) begin
			host_credits++;
			cur_returns++;
			if (host_credits > oflow_pkg::CUR_CREDITS) begin
				errors++;
				$display("Credit returned at time %0t with no object in the buffer", $time);
			end
		end
	end

	always @(posedge clk) begin
		if (match_valid) begin
			match_cnt++;
			owed++;
			checks++;
			if (q_found.size() == 0) begin
				errors++;
				$display("Unexpected result appeared at time %0t", $time);
			end else begin
				if (match_found !== q_found[0] || match_id !== q_id[0]
					|| match_score !== q_score[0]) begin
					errors++;
					$display("FAIL %0t: got found %0b id %0d score %0d, expected %0b %0d %0d",
						$time, match_found, match_id, match_score,
						q_found[0], q_id[0], q_score[0]);
				end
				void'(q_found.pop_front());
				void'(q_id.pop_front());
				void'(q_score.pop_front());
			end
		end
	end

	initial begin
		forever begin
			@(posedge clk);
			#2;
			match_credit_return = 1'b0;
			if (!hold_credits && owed > 0) begin
				match_credit_return = 1'b1;
				owed--;
			end
		end
	end

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		logic [FW-1:0] f;
		logic [FW-1:0] g;
		int base;
		for (int i = 0; i < 8; i++)
			tab_v[i] = 1'b0;
		repeat (5) @(posedge clk);
		#2;
		reset_N = 1'b1;

		// Exact match, only history and IoU remainder count
		rand_obj(12'h111, f);
		g = f;
		g[oflow_pkg::DHIST_LSB +: 8] = 8'd37;
		g[oflow_pkg::ID_LSB +: 12] = 12'h0a5;
		write_entry(4, g);
		send_obj(f, 1'b1, 12'h0a5, (32'(iou_weight) + 32'(dhistory_weight) * 37) / 6);
		end_test("exact_match");

		// Eight random entries, then a tie
		for (int i = 0; i < 8; i++) begin
			rand_obj(12'h200 + 12'(i), g);
			write_entry(i, g);
		end
		for (int n = 0; n < 3; n++) begin
			rand_obj(12'h300, f);
			send_ref(f);
		end
		wait_done();
		// Entries 3 and 6 equal the object except for the id
		rand_obj(12'h301, g);
		g[oflow_pkg::DHIST_LSB +: 8] = 8'd0;
		write_entry(3, g);
		g[oflow_pkg::ID_LSB +: 12] = 12'h777;
		write_entry(6, g);
		f = g;
		f[oflow_pkg::ID_LSB +: 12] = 12'h302;
		send_obj(f, 1'b1, 12'h301, 32'(iou_weight) / 6);
		end_test("best_of_many");

		// Empty table, then entries 2 and 5 only
		clear_table();
		rand_obj(12'h400, f);
		send_obj(f, 1'b0, 12'h000, 32'hffff_ffff);
		wait_done();
		rand_obj(12'h402, g);
		write_entry(2, g);
		rand_obj(12'h405, g);
		write_entry(5, g);
		rand_obj(12'h401, f);
		send_ref(f);
		end_test("empty_and_partial");

		// Disjoint boxes, then zero weights
		clear_table();
		g = pack_obj(11'd500, 11'd500, 11'd40, 11'd30, 24'h102030, 24'h405060, 8'd9, 12'h5aa);
		write_entry(0, g);
		f = pack_obj(11'd10, 11'd10, 11'd45, 11'd35, 24'h111111, 24'h222222, 8'd0, 12'h500);
		// No overlap, so the IoU term is the full 256
		send_obj(f, 1'b1, 12'h5aa, (32'(iou_weight) * 256 + 32'(w_weight) * 5
			+ 32'(h_weight) * 5 + 32'(color1_weight) * 47 + 32'(color2_weight) * 138
			+ 32'(dhistory_weight) * 9) / 6);
		wait_done();
		@(posedge clk);
		#2;
		w_weight = 8'd0;
		color1_weight = 8'd0;
		send_ref(f);
		end_test("disjoint_and_weights");
		w_weight = 8'd2;
		color1_weight = 8'd1;

		// Consumer withholds credits during four sends
		for (int i = 0; i < 8; i++) begin
			rand_obj(12'h600 + 12'(i), g);
			write_entry(i, g);
		end
		base = match_cnt;
		hold_credits = 1'b1;
		for (int n = 0; n < 4; n++) begin
			rand_obj(12'h700 + 12'(n), f);
			send_ref(f);
		end
		repeat (40) @(posedge clk);
		#2;
		if (match_cnt - base != oflow_pkg::MATCH_CREDITS) begin
			errors++;
			$display("Back-pressure let %0d results through instead of %0d",
				match_cnt - base, oflow_pkg::MATCH_CREDITS);
		end
		hold_credits = 1'b0;
		end_test("credit_backpressure");
		if (cur_returns != objs_sent) begin
			errors++;
			$display("Saw %0d credit returns for %0d sent objects", cur_returns, objs_sent);
		end

		$display("Summary: %0d results checked, %0d errors", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
